// ==== src.f ====
src/muldiv_pkg.sv
src/muldiv_issue.sv
src/mul_unit.sv
src/div_unit.sv
src/muldiv_result.sv
src/muldiv_top.sv
dv/muldiv_asserts.sv
dv/muldiv_tb.sv

// ==== dv/muldiv_tb.sv ====
module muldiv_tb
    import muldiv_pkg::*;
;

    localparam int N_MUL     = 48;
    localparam int N_DIV     = 48;
    localparam int N_ZERO    = 12;
    localparam int N_OVF     = 2;
    localparam int NUM_TESTS = N_MUL + N_DIV + N_ZERO + N_OVF;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (DIV_STEPS + 8) + 16;

    logic            clk;
    logic            reset;
    muldiv_op_e      op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic            hold;
    logic [XLEN-1:0] result;

    logic [31:0]     rng;                             // xorshift state
    int              value_errors;
    int              timing_errors;
    int              total_errors;

    muldiv_op_e mul_ops [4] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
    muldiv_op_e div_ops [4] = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};

    muldiv_top UUT (
        .clk         (clk),
        .reset       (reset),
        .op_i        (op),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .hold_o      (hold),
        .result_o    (result)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

//////////////////////////////////////////////////
// reference model, M-extension rules
//////////////////////////////////////////////////

    function automatic logic [31:0] model_result(input muldiv_op_e op_code,
                                                 input logic [31:0] a_val,
                                                 input logic [31:0] b_val);
        logic [63:0] a_sx;
        logic [63:0] b_sx;
        logic [63:0] a_zx;
        logic [63:0] b_zx;
        logic [63:0] prod;
        longint      sa;
        longint      sb;
        logic        ovf;
        a_sx = {{32{a_val[31]}}, a_val};
        b_sx = {{32{b_val[31]}}, b_val};
        a_zx = {32'd0, a_val};
        b_zx = {32'd0, b_val};
        sa   = $signed(a_sx);
        sb   = $signed(b_sx);
        ovf  = (a_val == 32'h8000_0000) && (b_val == 32'hffff_ffff);
        prod = '0;
        case (op_code)
            OP_MUL: begin
                prod = a_zx * b_zx;
                return prod[31:0];
            end
            OP_MULH: begin
                prod = a_sx * b_sx;
                return prod[63:32];
            end
            OP_MULHSU: begin
                prod = a_sx * b_zx;
                return prod[63:32];
            end
            OP_MULHU: begin
                prod = a_zx * b_zx;
                return prod[63:32];
            end
            OP_DIVU:   return (b_val == '0) ? 32'hffff_ffff : a_val / b_val;
            OP_REMU:   return (b_val == '0) ? a_val : a_val % b_val;
            OP_DIV:    return (b_val == '0) ? 32'hffff_ffff : ovf ? a_val : 32'(sa / sb);
            OP_REM:    return (b_val == '0) ? a_val : ovf ? 32'd0 : 32'(sa % sb);
            default:   return '0;
        endcase
    endfunction

    task automatic pick_operand(output logic [31:0] v);
        rng = xorshift32(rng);
        case (rng[2:0])
            3'd0: v = 32'd0;
            3'd1: v = 32'd1;
            3'd2: v = 32'hffff_ffff;                  // -1
            3'd3: v = 32'h8000_0000;                  // most negative
            default: begin
                rng = xorshift32(rng);
                v   = rng;
            end
        endcase
    endtask

    task automatic check_idle(input string name);
        assert (hold === 1'b0 && result === '0) else begin
            $display("Fail %s idle: expected hold 0 result %h, actual hold %b result %h",
                     name, 32'd0, hold, result);
            value_errors++;
        end
    endtask

    // exp_holds below zero leaves the hold length unchecked
    task automatic run_op(input muldiv_op_e op_code, input logic [31:0] a_val,
                          input logic [31:0] b_val, input string tag, input int exp_holds);
        int          holds;
        logic [31:0] expected;
        string       name;
        name     = $sformatf("%s %s a=%h b=%h", tag, op_code.name(), a_val, b_val);
        expected = model_result(op_code, a_val, b_val);
        holds    = 0;
        @(posedge clk);
        op        <= op_code;
        operand_a <= a_val;
        operand_b <= b_val;
        @(negedge clk);
        while (hold === 1'b1) begin                   // watchdog bounds this wait
            holds++;
            @(negedge clk);
        end
        assert (result === expected) else begin
            $display("Fail %s: expected %h, actual %h", name, expected, result);
            value_errors++;
        end
        if (exp_holds >= 0) begin
            assert (holds == exp_holds) else begin
                $display("Fail %s hold cycles: expected %0d, actual %0d", name, exp_holds, holds);
                timing_errors++;
            end
        end
        @(posedge clk);
        op <= OP_NONE;
        @(negedge clk);
        check_idle(name);
    endtask

//////////////////////////////////////////////////
// stimulus
//////////////////////////////////////////////////

    initial begin
        logic [31:0] a_val;
        logic [31:0] b_val;
        clk = 1'b0;
        reset = 1'b1;
        op = OP_NONE;
        operand_a = '0;
        operand_b = '0;
        rng = 32'h4458f0cc;
        value_errors = 0;
        timing_errors = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_idle("after reset");
        for (int i = 0; i < N_MUL; i++) begin
            pick_operand(a_val);
            pick_operand(b_val);
            rng = xorshift32(rng);
            run_op(mul_ops[rng[1:0]], a_val, b_val, "mul", 2);
        end
        for (int i = 0; i < N_DIV; i++) begin
            pick_operand(a_val);
            pick_operand(b_val);
            rng = xorshift32(rng);
            run_op(div_ops[rng[1:0]], a_val, b_val, "div", -1);
        end
        for (int i = 0; i < N_ZERO; i++) begin
            pick_operand(a_val);
            run_op(div_ops[i % 4], a_val, 32'd0, "zero divisor", 1);
        end
        run_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff, "overflow", -1);
        run_op(OP_REM, 32'h8000_0000, 32'hffff_ffff, "overflow", -1);
        repeat (2) @(posedge clk);
        total_errors = value_errors + timing_errors + int'(UUT.u_asserts.fail_count);
        $display("errors: value %0d, timing %0d, assertion %0d",
                 value_errors, timing_errors, UUT.u_asserts.fail_count);
        if (total_errors == 0) begin
            $display("TEST PASS");
        end
        else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT hung with hold high",
                 WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== dv/muldiv_asserts.sv ====
module muldiv_asserts
    import muldiv_pkg::*;
(
    input logic            clk,
    input logic            reset,
    input logic            hold_i,
    input logic            mul_start_i,
    input logic            div_start_i,
    input logic            div_busy_i,
    input div_state_e      div_state_i,
    input logic [XLEN-1:0] operand_b_i
);

    int unsigned fail_count;                          // assertion failures so far

    initial fail_count = 0;

//////////////////////////////////////////////////
// hold and start timing
//////////////////////////////////////////////////

    reset_idle: assert property (@(posedge clk) $fell(reset) |-> !hold_i)
        else begin
            $error("hold high right after reset");
            fail_count++;
        end

    // stage cycle stays held, then hold drops
    mul_hold: assert property (@(posedge clk) disable iff (reset)
        mul_start_i |=> hold_i ##1 !hold_i)
        else begin
            $error("multiply start not followed by exactly two hold cycles");
            fail_count++;
        end

    // no second start once the divider finishes
    div_hold: assert property (@(posedge clk) disable iff (reset)
        $fell(div_busy_i) |-> !hold_i)
        else begin
            $error("hold still high after the divider finished");
            fail_count++;
        end

    // zero divisor settles at start
    div_zero_idle: assert property (@(posedge clk) disable iff (reset)
        (div_start_i && operand_b_i == '0) |=> (div_state_i == D_IDLE))
        else begin
            $error("divider left idle on a zero divisor");
            fail_count++;
        end

endmodule

bind muldiv_top muldiv_asserts u_asserts (
    .clk         (clk),
    .reset       (reset),
    .hold_i      (hold_o),
    .mul_start_i (mul_start),
    .div_start_i (div_start),
    .div_busy_i  (div_busy),
    .div_state_i (u_div.state_q),
    .operand_b_i (operand_b_i)
);

// ==== src/muldiv_top.sv ====
module muldiv_top
    import muldiv_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    input  muldiv_op_e      op_i,
    input  logic [XLEN-1:0] operand_a_i,
    input  logic [XLEN-1:0] operand_b_i,

    output logic            hold_o,
    output logic [XLEN-1:0] result_o
);

    logic              mul_start;
    logic              div_start;
    logic              a_signed;
    logic              b_signed;
    logic              mul_busy;
    logic              div_busy;
    logic [2*XLEN-1:0] product;
    logic [XLEN-1:0]   quotient;
    logic [XLEN-1:0]   remainder;

    muldiv_issue u_issue (
        .clk         (clk),
        .reset       (reset),
        .op_i        (op_i),
        .mul_busy_i  (mul_busy),
        .div_busy_i  (div_busy),
        .mul_start_o (mul_start),
        .div_start_o (div_start),
        .a_signed_o  (a_signed),
        .b_signed_o  (b_signed),
        .hold_o      (hold_o)
    );

    mul_unit u_mul (
        .clk         (clk),
        .reset       (reset),
        .start_i     (mul_start),
        .a_signed_i  (a_signed),
        .b_signed_i  (b_signed),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .busy_o      (mul_busy),
        .product_o   (product)
    );

    div_unit u_div (
        .clk         (clk),
        .reset       (reset),
        .start_i     (div_start),
        .signed_i    (a_signed),                      // DIV and REM treat both as signed
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .busy_o      (div_busy),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    muldiv_result u_result (
        .op_i        (op_i),
        .product_i   (product),
        .quotient_i  (quotient),
        .remainder_i (remainder),
        .result_o    (result_o)
    );

endmodule

// ==== src/muldiv_result.sv ====
module muldiv_result
    import muldiv_pkg::*;
(
    input  muldiv_op_e        op_i,
    input  logic [2*XLEN-1:0] product_i,
    input  logic [XLEN-1:0]   quotient_i,
    input  logic [XLEN-1:0]   remainder_i,

    output logic [XLEN-1:0]   result_o
);

    logic [XLEN-1:0] prod_lo;
    logic [XLEN-1:0] prod_hi;

    assign prod_lo = product_i[XLEN-1:0];
    assign prod_hi = product_i[2*XLEN-1:XLEN];

    always_comb begin
        case (op_i)
            OP_MUL: begin
                result_o = prod_lo;
            end
            OP_MULH, OP_MULHSU, OP_MULHU: begin
                result_o = prod_hi;                   // signedness already in the product
            end
            OP_DIV, OP_DIVU: begin
                result_o = quotient_i;
            end
            OP_REM, OP_REMU: begin
                result_o = remainder_i;
            end
            default: begin
                result_o = '0;                        // idle output reads zero
            end
        endcase
    end

endmodule

// ==== src/div_unit.sv ====
module div_unit
    import muldiv_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    input  logic            start_i,
    input  logic            signed_i,
    input  logic [XLEN-1:0] operand_a_i,
    input  logic [XLEN-1:0] operand_b_i,

    output logic            busy_o,
    output logic [XLEN-1:0] quotient_o,
    output logic [XLEN-1:0] remainder_o
);

    div_state_e           state_q;
    logic [DIV_CNT_W-1:0] step_q;

    logic [XLEN-1:0]      quo_q;                      // dividend shifts out, quotient in
    logic [XLEN-1:0]      rem_q;                      // partial remainder
    logic [XLEN-1:0]      divisor_q;                  // divisor magnitude
    logic                 quo_neg_q;
    logic                 rem_neg_q;

    logic                 a_neg;
    logic                 b_neg;
    logic [XLEN-1:0]      a_mag;
    logic [XLEN-1:0]      b_mag;
    logic                 div_zero;
    logic                 overflow;
    logic [XLEN:0]        rem_shift;
    logic [XLEN:0]        rem_diff;

//////////////////////////////////////////////////
// operand preparation
//////////////////////////////////////////////////

    assign a_neg = signed_i & operand_a_i[XLEN-1];
    assign b_neg = signed_i & operand_b_i[XLEN-1];
    assign a_mag = a_neg ? -operand_a_i : operand_a_i;  // most negative maps to itself
    assign b_mag = b_neg ? -operand_b_i : operand_b_i;

    assign div_zero = (operand_b_i == '0);
    assign overflow = signed_i
                   && (operand_a_i == {1'b1, {(XLEN-1){1'b0}}})
                   && (operand_b_i == '1);

//////////////////////////////////////////////////
// one restoring step
//////////////////////////////////////////////////

    // partial remainder stays below the divisor, so 33 bits cover the trial
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, divisor_q};  // msb set means no subtract

//////////////////////////////////////////////////
// control
//////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= D_IDLE;
            step_q  <= '0;
        end
        else begin
            case (state_q)
                D_IDLE: begin
                    if (start_i && !div_zero && !overflow) begin
                        state_q <= D_CALC;
                        step_q  <= '0;
                    end
                end
                D_CALC: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == DIV_CNT_W'(DIV_STEPS - 1)) begin
                        state_q <= D_FIX;
                    end
                end
                D_FIX: begin
                    state_q <= D_IDLE;
                end
                default: begin
                    state_q <= D_IDLE;
                end
            endcase
        end
    end

//////////////////////////////////////////////////
// data path
//////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        case (state_q)
            D_IDLE: begin
                if (start_i) begin
                    if (div_zero) begin
                        quo_q <= '1;                  // all ones quotient
                        rem_q <= operand_a_i;
                    end
                    else if (overflow) begin
                        quo_q <= operand_a_i;
                        rem_q <= '0;
                    end
                    else begin
                        quo_q     <= a_mag;
                        rem_q     <= '0;
                        divisor_q <= b_mag;
                        quo_neg_q <= a_neg ^ b_neg;
                        rem_neg_q <= a_neg;           // remainder follows the dividend
                    end
                end
            end
            D_CALC: begin
                rem_q <= rem_diff[XLEN] ? rem_shift[XLEN-1:0] : rem_diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], ~rem_diff[XLEN]};
            end
            D_FIX: begin
                quo_q <= quo_neg_q ? -quo_q : quo_q;
                rem_q <= rem_neg_q ? -rem_q : rem_q;
            end
            default: begin
                quo_q <= quo_q;
            end
        endcase
    end

    assign busy_o      = (state_q != D_IDLE);
    assign quotient_o  = quo_q;
    assign remainder_o = rem_q;

endmodule

// ==== src/mul_unit.sv ====
module mul_unit
    import muldiv_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    input  logic              start_i,
    input  logic              a_signed_i,
    input  logic              b_signed_i,
    input  logic [XLEN-1:0]   operand_a_i,
    input  logic [XLEN-1:0]   operand_b_i,

    output logic              busy_o,
    output logic [2*XLEN-1:0] product_o
);

    logic                     stage_q;                // high in the cycle after start
    logic signed [XLEN:0]     a_ext_q;                // 33 bit extended operands
    logic signed [XLEN:0]     b_ext_q;
    logic signed [2*XLEN+1:0] full_product;
    logic [2*XLEN-1:0]        product_q;

    // both operands signed here, so one multiplier serves every variant
    assign full_product = a_ext_q * b_ext_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q <= 1'b0;
        end
        else begin
            stage_q <= start_i;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            a_ext_q <= {a_signed_i & operand_a_i[XLEN-1], operand_a_i};
            b_ext_q <= {b_signed_i & operand_b_i[XLEN-1], operand_b_i};
        end
        if (stage_q) begin
            product_q <= full_product[2*XLEN-1:0];    // upper two bits are sign only
        end
    end

    assign busy_o    = stage_q;
    assign product_o = product_q;

endmodule

// ==== src/muldiv_issue.sv ====
module muldiv_issue
    import muldiv_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  muldiv_op_e op_i,
    input  logic       mul_busy_i,
    input  logic       div_busy_i,

    output logic       mul_start_o,
    output logic       div_start_o,
    output logic       a_signed_o,
    output logic       b_signed_o,
    output logic       hold_o
);

    muldiv_op_e last_op_q;                            // op seen in the previous cycle
    logic       served_q;                             // presented op already started

    logic       is_mul;
    logic       is_div;
    logic       unit_busy;
    logic       fresh;
    logic       issue;

//////////////////////////////////////////////////
// operation class and signedness
//////////////////////////////////////////////////

    assign is_mul = op_i inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
    assign is_div = op_i inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

    assign a_signed_o = op_i inside {OP_MULH, OP_MULHSU, OP_DIV, OP_REM};
    assign b_signed_o = op_i inside {OP_MULH, OP_DIV, OP_REM};  // MULHSU keeps b unsigned

//////////////////////////////////////////////////
// start generation
//////////////////////////////////////////////////

    assign unit_busy = mul_busy_i | div_busy_i;

    // a new op is one that differs from last cycle, or one not yet started
    assign fresh = !served_q || (op_i != last_op_q);

    assign issue = (is_mul | is_div) && fresh && !unit_busy;

    assign mul_start_o = issue & is_mul;              // single cycle pulse
    assign div_start_o = issue & is_div;              // single cycle pulse

    assign hold_o = mul_start_o | div_start_o | unit_busy;

//////////////////////////////////////////////////
// served tracking
//////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            last_op_q <= OP_NONE;
            served_q  <= 1'b0;
        end
        else begin
            last_op_q <= op_i;
            // stays set while the same op is held, drops on OP_NONE or a change
            served_q  <= issue
                       | (served_q & (op_i == last_op_q) & (op_i != OP_NONE));
        end
    end

endmodule

// ==== src/muldiv_pkg.sv ====
package muldiv_pkg;

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

    localparam int XLEN      = 32;                    // data path width
    localparam int DIV_STEPS = XLEN;                  // one quotient bit per step
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);     // step counter width

//////////////////////////////////////////////////
// operation codes
//////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_NONE   = 4'd0,                             // no operation presented
        OP_MUL    = 4'd1,                             // low half, sign agnostic
        OP_MULH   = 4'd2,                             // high half, signed x signed
        OP_MULHSU = 4'd3,                             // high half, signed x unsigned
        OP_MULHU  = 4'd4,                             // high half, unsigned x unsigned
        OP_DIV    = 4'd5,
        OP_DIVU   = 4'd6,
        OP_REM    = 4'd7,
        OP_REMU   = 4'd8
    } muldiv_op_e;

//////////////////////////////////////////////////
// divider FSM
//////////////////////////////////////////////////

    typedef enum logic [1:0] {
        D_IDLE = 2'd0,                                // waiting, special cases settle here
        D_CALC = 2'd1,                                // shift-subtract iterations
        D_FIX  = 2'd2                                 // apply result signs
    } div_state_e;

endpackage
